/* ecc_sram_top.f */
+incdir+common
common/ecc_code_pkg.sv
common/ecc_mem_pkg.sv
source/secded_enc.sv
source/secded_dec.sv
source/sram_bank.sv
ecc_scrubber/ecc_scrubber.sv
source/ecc_sram_top.sv
tests/tb_ecc_sram_top.sv

/* tests/tb_ecc_sram_top.sv */
// Table-driven testbench for the ECC SRAM bank with access port and scrubber
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module tb_ecc_sram_top;

  import ecc_code_pkg::*;
  import ecc_mem_pkg::*;

  localparam int Words = `ECC_BANK_WORDS;
  localparam int CodeW = `ECC_DATA_WIDTH + `ECC_PROT_WIDTH;

  typedef enum int {OpWrite, OpRead, OpIdle, OpScrubStart, OpScrubWait} op_e;
  typedef enum int {KindClean, KindSingle, KindDouble} kind_e;

  // One stimulus step with its expected read response
  typedef struct {
    op_e      op;
    addr_t    addr;
    data_t    data;
    code_t    mask;
    data_t    exp_data;
    logic     chk_data;
    ecc_err_e exp_err;
  } row_t;

  logic         clk_i;
  logic         rst_ni;
  logic         req_i;
  logic         we_i;
  addr_t        addr_i;
  data_t        wdata_i;
  code_t        inject_mask_i;
  logic         rvalid_o;
  data_t        rdata_o;
  ecc_err_e     rerr_o;
  logic         scrub_trigger_i;
  logic         scrub_corrected_o;
  logic         scrub_fatal_o;

  integer       seed;
  row_t         rows[$];
  data_t        ref_data[Words];
  kind_e        ref_kind[Words];
  int           n_single;
  int           n_double;
  int           corrected_cnt;
  int           fatal_cnt;
  int           done_cnt;
  int           cycle_cnt;
  int           cycle_limit;
  scrub_state_e prev_state;
  // Read issued in the previous cycle and checked in this one
  logic         pending;
  addr_t        pend_addr;
  data_t        pend_data;
  logic         pend_chk;
  ecc_err_e     pend_err;

  ecc_sram_top uut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_i             (req_i),
    .we_i              (we_i),
    .addr_i            (addr_i),
    .wdata_i           (wdata_i),
    .inject_mask_i     (inject_mask_i),
    .rvalid_o          (rvalid_o),
    .rdata_o           (rdata_o),
    .rerr_o            (rerr_o),
    .scrub_trigger_i   (scrub_trigger_i),
    .scrub_corrected_o (scrub_corrected_o),
    .scrub_fatal_o     (scrub_fatal_o)
  );

  always #5 clk_i = ~clk_i;

  // Run limit from the table length and one scrub pass
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  // Scrub pulses and finished addresses sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (scrub_corrected_o) begin
        corrected_cnt = corrected_cnt + 1;
      end
      if (scrub_fatal_o) begin
        fatal_cnt = fatal_cnt + 1;
      end
      // A return from Check to Idle ends one address of any class
      if (prev_state == ScrubCheck && uut.i_scrubber.state_q == ScrubIdle) begin
        done_cnt = done_cnt + 1;
      end
    end
    prev_state = uut.i_scrubber.state_q;
  end

  task automatic check_data(data_t got, data_t exp, string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s data %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_err(ecc_err_e got, ecc_err_e exp, string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s class %s, expected %s", $time, what, got.name(),
               exp.name());
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_count(int got, int exp, string what);
    if (got != exp) begin
      $display("Mismatch at %0t: %s count %0d, expected %0d", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_valid(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s rvalid %b, expected %b", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  function automatic row_t make_row(op_e op, addr_t a, data_t d, code_t m, data_t ed,
                                    logic chk, ecc_err_e ee);
    row_t r;
    r.op       = op;
    r.addr     = a;
    r.data     = d;
    r.mask     = m;
    r.exp_data = ed;
    r.chk_data = chk;
    r.exp_err  = ee;
    return r;
  endfunction

  // Zero, one or two distinct random bits anywhere in the codeword
  function automatic code_t make_mask(kind_e kind);
    int    p0;
    int    p1;
    code_t m;
    m  = '0;
    p0 = 0;
    if (kind != KindClean) begin
      p0    = $unsigned($random(seed)) % CodeW;
      m[p0] = 1'b1;
    end
    if (kind == KindDouble) begin
      p1 = p0;
      while (p1 == p0) begin
        p1 = $unsigned($random(seed)) % CodeW;
      end
      m[p1] = 1'b1;
    end
    return m;
  endfunction

  task automatic add_write(int a, kind_e kind);
    data_t d;
    d           = data_t'($random(seed));
    ref_data[a] = d;
    ref_kind[a] = kind;
    rows.push_back(make_row(OpWrite, addr_t'(a), d, make_mask(kind), '0, 1'b0, ErrNone));
  endtask

  // Expected class follows the stored error and whether the scrubber fixed it
  task automatic add_read(int a, logic scrubbed);
    ecc_err_e ee;
    logic     chk;
    chk = 1'b1;
    ee  = ErrNone;
    if (ref_kind[a] == KindSingle && !scrubbed) begin
      ee = ErrCorrected;
    end else if (ref_kind[a] == KindDouble) begin
      ee  = ErrFatal;
      chk = 1'b0;
    end
    rows.push_back(make_row(OpRead, addr_t'(a), '0, '0, ref_data[a], chk, ee));
  endtask

  task automatic build_table();
    int n;
    // Round trips with clean, single and double errors
    for (int i = 0; i < 9; i++) begin
      add_write(i, kind_e'(i % 3));
      add_read(i, 1'b0);
    end
    // Fill the bank with one single-error and one double-error word in every four
    n_single = 0;
    n_double = 0;
    for (int a = 0; a < Words; a++) begin
      if (a % 4 == 1) begin
        add_write(a, KindSingle);
        n_single++;
      end else if (a % 4 == 3) begin
        add_write(a, KindDouble);
        n_double++;
      end else begin
        add_write(a, KindClean);
      end
    end
    rows.push_back(make_row(OpScrubStart, '0, '0, '0, '0, 1'b0, ErrNone));
    // Reads of clean words during the pass with a gap after every third
    n = 0;
    for (int a = 0; a < Words && n < 12; a++) begin
      if (ref_kind[a] == KindClean) begin
        add_read(a, 1'b0);
        n++;
        if (n % 3 == 0) begin
          rows.push_back(make_row(OpIdle, '0, '0, '0, '0, 1'b0, ErrNone));
        end
      end
    end
    rows.push_back(make_row(OpScrubWait, '0, '0, '0, '0, 1'b0, ErrNone));
    // Whole bank after the pass
    for (int a = 0; a < Words; a++) begin
      add_read(a, 1'b1);
    end
  endtask

  // Dropping the trigger while the last address is in flight limits the run to one pass
  task automatic wait_scrub_pass();
    while (done_cnt < Words - 1) begin
      @(posedge clk_i);
    end
    scrub_trigger_i <= 1'b0;
    while (done_cnt < Words) begin
      @(posedge clk_i);
    end
    check_count(corrected_cnt, n_single, "scrub corrected pulses");
    check_count(fatal_cnt, n_double, "scrub fatal pulses");
  endtask

  task automatic apply_row(row_t r);
    @(posedge clk_i);
    req_i         <= (r.op == OpWrite) || (r.op == OpRead);
    we_i          <= (r.op == OpWrite);
    addr_i        <= r.addr;
    wdata_i       <= r.data;
    inject_mask_i <= r.mask;
    if (r.op == OpScrubStart) begin
      scrub_trigger_i <= 1'b1;
    end
    @(negedge clk_i);
    // Response of the previous row's read lands in this cycle only
    if (pending) begin
      check_valid(rvalid_o, 1'b1, $sformatf("read of word %0d", pend_addr));
      if (pend_chk) begin
        check_data(rdata_o, pend_data, $sformatf("read of word %0d", pend_addr));
      end
      check_err(rerr_o, pend_err, $sformatf("read of word %0d", pend_addr));
    end else begin
      check_valid(rvalid_o, 1'b0, "cycle without a read");
    end
    pending   = (r.op == OpRead);
    pend_addr = r.addr;
    pend_data = r.exp_data;
    pend_chk  = r.chk_data;
    pend_err  = r.exp_err;
    if (r.op == OpScrubWait) begin
      wait_scrub_pass();
    end
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    req_i           = 1'b0;
    we_i            = 1'b0;
    addr_i          = '0;
    wdata_i         = '0;
    inject_mask_i   = '0;
    scrub_trigger_i = 1'b0;
    seed            = 38236;
    corrected_cnt   = 0;
    fatal_cnt       = 0;
    done_cnt        = 0;
    cycle_cnt       = 0;
    pending         = 1'b0;
    prev_state      = ScrubIdle;
    build_table();
    cycle_limit = rows.size() * 4 + Words * 3 * 4 + 8 + 100;

    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    // One quiet cycle collects the last read
    apply_row(make_row(OpIdle, '0, '0, '0, '0, 1'b0, ErrNone));

    // Readback after the pass must not have woken the scrubber
    check_count(corrected_cnt, n_single, "final scrub corrected pulses");
    check_count(fatal_cnt, n_double, "final scrub fatal pulses");
    check_count(done_cnt, Words, "finished scrub addresses");

    $display("TB PASSED");
    $finish;
  end

endmodule

/* source/ecc_sram_top.sv */
// ECC-protected SRAM bank with access port and background scrubber
`timescale 1ns/1ps

module ecc_sram_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  ecc_mem_pkg::addr_t       addr_i,
  input  ecc_code_pkg::data_t      wdata_i,
  input  ecc_code_pkg::code_t      inject_mask_i,
  output logic                     rvalid_o,
  output ecc_code_pkg::data_t      rdata_o,
  output ecc_code_pkg::ecc_err_e   rerr_o,
  input  logic                     scrub_trigger_i,
  output logic                     scrub_corrected_o,
  output logic                     scrub_fatal_o
);

  import ecc_code_pkg::*;
  import ecc_mem_pkg::*;

  code_t enc_code;
  logic  bank_req;
  logic  bank_we;
  addr_t bank_addr;
  code_t bank_wdata;
  code_t bank_rdata;
  logic  rvalid_q;

  // Write data plus injected faults
  secded_enc i_enc (
    .data_i        (wdata_i),
    .inject_mask_i (inject_mask_i),
    .code_o        (enc_code)
  );

  // Scrubber sits between the access port and the bank
  ecc_scrubber i_scrubber (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .scrub_trigger_i   (scrub_trigger_i),
    .scrub_corrected_o (scrub_corrected_o),
    .scrub_fatal_o     (scrub_fatal_o),
    .intc_req_i        (req_i),
    .intc_we_i         (we_i),
    .intc_addr_i       (addr_i),
    .intc_wdata_i      (enc_code),
    .bank_req_o        (bank_req),
    .bank_we_o         (bank_we),
    .bank_addr_o       (bank_addr),
    .bank_wdata_o      (bank_wdata),
    .bank_rdata_i      (bank_rdata)
  );

  sram_bank i_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bank_req),
    .we_i    (bank_we),
    .addr_i  (bank_addr),
    .wdata_i (bank_wdata),
    .rdata_o (bank_rdata)
  );

  // Read path, valid in the cycle after the request
  secded_dec i_read_dec (
    .code_i     (bank_rdata),
    .code_o     (),
    .data_o     (rdata_o),
    .syndrome_o (),
    .err_o      (rerr_o)
  );

  // Fixed one-cycle read latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i & ~we_i;
    end
  end

  assign rvalid_o = rvalid_q;

endmodule

/* ecc_scrubber/ecc_scrubber.sv */
// Background scrubber that walks the bank and writes back corrected words
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_scrubber (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                scrub_trigger_i,
  output logic                scrub_corrected_o,
  output logic                scrub_fatal_o,
  input  logic                intc_req_i,
  input  logic                intc_we_i,
  input  ecc_mem_pkg::addr_t  intc_addr_i,
  input  ecc_code_pkg::code_t intc_wdata_i,
  output logic                bank_req_o,
  output logic                bank_we_o,
  output ecc_mem_pkg::addr_t  bank_addr_o,
  output ecc_code_pkg::code_t bank_wdata_o,
  input  ecc_code_pkg::code_t bank_rdata_i
);

  import ecc_code_pkg::*;
  import ecc_mem_pkg::*;

  scrub_state_e state_d, state_q;
  addr_t        addr_d, addr_q;
  addr_t        addr_next;
  logic         scrub_req;
  logic         scrub_we;
  code_t        fixed_code;
  ecc_err_e     scrub_err;

  // Private decoder on the bank read data
  secded_dec i_scrub_dec (
    .code_i     (bank_rdata_i),
    .code_o     (fixed_code),
    .data_o     (),
    .syndrome_o (),
    .err_o      (scrub_err)
  );

  // Wrap at the bank depth
  assign addr_next = (addr_q == addr_t'(`ECC_BANK_WORDS - 1)) ? '0 : addr_q + 1'b1;

  // Access side owns the port whenever it asks
  always_comb begin
    if (intc_req_i) begin
      bank_req_o   = 1'b1;
      bank_we_o    = intc_we_i;
      bank_addr_o  = intc_addr_i;
      bank_wdata_o = intc_wdata_i;
    end else begin
      bank_req_o   = scrub_req;
      bank_we_o    = scrub_we;
      bank_addr_o  = addr_q;
      bank_wdata_o = fixed_code;
    end
  end

  always_comb begin
    state_d           = state_q;
    addr_d            = addr_q;
    scrub_req         = 1'b0;
    scrub_we          = 1'b0;
    scrub_corrected_o = 1'b0;
    scrub_fatal_o     = 1'b0;

    unique case (state_q)
      ScrubIdle: begin
        if (scrub_trigger_i) begin
          state_d = ScrubRead;
        end
      end
      ScrubRead: begin
        // Read only counts when the access side is quiet
        scrub_req = 1'b1;
        if (!intc_req_i) begin
          state_d = ScrubCheck;
        end
      end
      ScrubCheck: begin
        if (scrub_err != ErrCorrected) begin
          // Clean and fatal words stay as they are
          scrub_fatal_o = (scrub_err == ErrFatal);
          addr_d        = addr_next;
          state_d       = ScrubIdle;
        end else if (intc_req_i) begin
          // An access took the port and the word may have changed so read again
          state_d = ScrubRead;
        end else begin
          scrub_req         = 1'b1;
          scrub_we          = 1'b1;
          scrub_corrected_o = 1'b1;
          addr_d            = addr_next;
          state_d           = ScrubIdle;
        end
      end
      default: begin
        state_d = ScrubIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ScrubIdle;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
    end
  end

  // One verdict per address
  a_one_flag: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(scrub_corrected_o && scrub_fatal_o)
  ) else $error("corrected and fatal flagged together");

  // Write-back follows an uninterrupted read of the same word and never meets an access
  a_access_priority: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    scrub_corrected_o |-> !intc_req_i && !$past(intc_req_i) &&
                          (bank_addr_o == $past(bank_addr_o))
  ) else $error("scrub write-back collided with access traffic");

endmodule

/* source/sram_bank.sv */
// Single-port codeword storage with synchronous write and one-cycle read
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module sram_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                we_i,
  input  ecc_mem_pkg::addr_t  addr_i,
  input  ecc_code_pkg::code_t wdata_i,
  output ecc_code_pkg::code_t rdata_o
);

  import ecc_code_pkg::*;

  // Contents undefined until written
  code_t mem_q [`ECC_BANK_WORDS];
  code_t rdata_q;

  // Write lands at the edge, read data registered for the next cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  // Holds the last read word until the next read
  assign rdata_o = rdata_q;

  // Requests stay inside the array
  a_addr_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (int'(addr_i) < `ECC_BANK_WORDS)
  ) else $error("bank request beyond the last word");

endmodule

/* source/secded_dec.sv */
// Hsiao SECDED decoder that corrects single-bit errors and flags double-bit errors
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module secded_dec (
  input  ecc_code_pkg::code_t     code_i,
  output ecc_code_pkg::code_t     code_o,
  output ecc_code_pkg::data_t     data_o,
  output ecc_code_pkg::syndrome_t syndrome_o,
  output ecc_code_pkg::ecc_err_e  err_o
);

  import ecc_code_pkg::*;

  syndrome_t syndrome;
  code_t     flip;
  ecc_err_e  err;

  always_comb begin
    // Stored check bits against recomputed ones
    syndrome = calc_check(code_i[`ECC_DATA_WIDTH-1:0]) ^
               code_i[`ECC_DATA_WIDTH+`ECC_PROT_WIDTH-1:`ECC_DATA_WIDTH];

    // Locate the failing bit among data columns
    flip = '0;
    for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
      if (syndrome == HsiaoCols[i]) begin
        flip[i] = 1'b1;
      end
    end
    // Check-bit columns are unit vectors
    for (int j = 0; j < `ECC_PROT_WIDTH; j++) begin
      if (syndrome == (syndrome_t'(1) << j)) begin
        flip[`ECC_DATA_WIDTH+j] = 1'b1;
      end
    end

    // Odd weight with a matching column is a single error
    // even weight or no match means at least two bits are bad
    if (syndrome == '0) begin
      err = ErrNone;
    end else if (^syndrome && |flip) begin
      err = ErrCorrected;
    end else begin
      err = ErrFatal;
    end
  end

  // Fatal words pass through untouched
  assign code_o     = (err == ErrCorrected) ? (code_i ^ flip) : code_i;
  assign data_o     = code_o[`ECC_DATA_WIDTH-1:0];
  assign syndrome_o = syndrome;
  assign err_o      = err;

  // A corrected class needs a nonzero syndrome and must leave a clean codeword behind
  always_comb begin
    assert final (err_o != ErrCorrected ||
                  (syndrome_o != '0 &&
                   calc_check(code_o[`ECC_DATA_WIDTH-1:0]) ==
                   code_o[`ECC_DATA_WIDTH+`ECC_PROT_WIDTH-1:`ECC_DATA_WIDTH]))
      else $error("corrected class without a syndrome or with an uncleared error");
  end

endmodule

/* source/secded_enc.sv */
// Hsiao SECDED encoder with a fault-injection mask on the codeword
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module secded_enc (
  input  ecc_code_pkg::data_t data_i,
  input  ecc_code_pkg::code_t inject_mask_i,
  output ecc_code_pkg::code_t code_o
);

  import ecc_code_pkg::*;

  syndrome_t check;
  code_t     clean_code;

  // Check bits from the shared column table
  always_comb begin
    check = calc_check(data_i);
  end

  // Payload low, check bits high
  assign clean_code = {check, data_i};

  // Mask flips chosen bits so that errors can be stored on purpose
  // All-zero mask in normal operation
  assign code_o = clean_code ^ inject_mask_i;

endmodule

/* common/ecc_mem_pkg.sv */
// Memory-side types for the ECC SRAM bank and its scrubber
`include "ecc_cfg.svh"

package ecc_mem_pkg;

  // Word address into the bank
  typedef logic [`ECC_ADDR_WIDTH-1:0] addr_t;

  // Scrubber sequence
  // Idle waits for the trigger
  // Read issues a bank read in a free cycle
  // Check decodes the returned word and writes back if needed
  typedef enum logic [1:0] {
    ScrubIdle  = 2'b00,
    ScrubRead  = 2'b01,
    ScrubCheck = 2'b10
  } scrub_state_e;

endpackage

/* common/ecc_code_pkg.sv */
// SECDED code types, Hsiao column table and check-bit function
`include "ecc_cfg.svh"

package ecc_code_pkg;

  typedef logic [`ECC_DATA_WIDTH-1:0]                   data_t;
  // Data in the low bits, check bits on top
  typedef logic [`ECC_DATA_WIDTH+`ECC_PROT_WIDTH-1:0]   code_t;
  typedef logic [`ECC_PROT_WIDTH-1:0]                   syndrome_t;
  typedef syndrome_t [`ECC_DATA_WIDTH-1:0]              col_table_t;

  // Bit 0 flags a correctable word, bit 1 an uncorrectable one
  typedef enum logic [1:0] {
    ErrNone      = 2'b00,
    ErrCorrected = 2'b01,
    ErrFatal     = 2'b10
  } ecc_err_e;

  // Picks the first weight-3 patterns in ascending order, one per data bit
  function automatic col_table_t gen_cols();
    col_table_t  cols;
    int unsigned n;
    syndrome_t   s;
    cols = '0;
    n    = 0;
    for (int v = 0; v < 2 ** `ECC_PROT_WIDTH; v++) begin
      s = syndrome_t'(v);
      if ($countones(s) == 3 && n < `ECC_DATA_WIDTH) begin
        cols[n] = s;
        n++;
      end
    end
    return cols;
  endfunction

  parameter col_table_t HsiaoCols = gen_cols();

  // Each check bit is the parity of the data bits whose column sets it
  function automatic syndrome_t calc_check(data_t data);
    syndrome_t chk;
    chk = '0;
    for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
      chk ^= {`ECC_PROT_WIDTH{data[i]}} & HsiaoCols[i];
    end
    return chk;
  endfunction

endpackage

/* common/ecc_cfg.svh */
// ECC SRAM configuration for payload width, check width and bank depth
`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

// Payload bits per stored word
`define ECC_DATA_WIDTH 32

// Hsiao check bits, enough for SECDED over 32 bits
`define ECC_PROT_WIDTH 7

// Words held by the bank
`define ECC_BANK_WORDS 64

// Address bits, log2 of the bank depth
`define ECC_ADDR_WIDTH 6

`endif
